//--- Bender.yml
package:
  name: beamformer

sources:
  - include_dirs:
      - hw
    files:
      - hw/beamformer_pkg.sv
      - hw/pipeline_control.sv
      - hw/weight_bank.sv
      - hw/channel_weighter.sv
      - hw/beam_summer.sv
      - hw/beamformer_top.sv
  - target: test
    files:
      - tb/beamformer_assertions.sv
      - tb/beamformer_tb.sv

//--- hw/beam_summer.sv
/*
 * Final stage of the beamformer.
 * Adds the four weighted channels sample by sample and registers the
 * combined real and imaginary beats, which are the design's output data.
 */
`timescale 1ns/1ps
`include "beamformer_settings.svh"

module beam_summer (
    input  logic                  clock,
    input  logic                  advance,
    input  beamformer_pkg::beat_t real_00,
    input  beamformer_pkg::beat_t real_01,
    input  beamformer_pkg::beat_t real_20,
    input  beamformer_pkg::beat_t real_21,
    input  beamformer_pkg::beat_t imag_00,
    input  beamformer_pkg::beat_t imag_01,
    input  beamformer_pkg::beat_t imag_20,
    input  beamformer_pkg::beat_t imag_21,
    output beamformer_pkg::beat_t beam_real_data,
    output beamformer_pkg::beat_t beam_imag_data
);

    // per-sample sum of four beats, each lane wraps at 16 bits on its own
    function automatic beamformer_pkg::beat_t add_beats(input beamformer_pkg::beat_t a,
                                                        input beamformer_pkg::beat_t b,
                                                        input beamformer_pkg::beat_t c,
                                                        input beamformer_pkg::beat_t d);
        beamformer_pkg::beat_t total;
        for (int s = 0; s < `BF_SAMPLES; s++) begin
            total[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH] =
                a[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH] +
                b[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH] +
                c[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH] +
                d[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH];
        end
        return total;
    endfunction

    // holds under back-pressure so the output beat stays put
    always_ff @(posedge clock) begin
        if (advance) begin
            beam_real_data <= add_beats(real_00, real_01, real_20, real_21);
            beam_imag_data <= add_beats(imag_00, imag_01, imag_20, imag_21);
        end
    end

endmodule

//--- hw/beamformer_pkg.sv
/*
 * Shared types for the beamformer datapath.
 * Modules refer to these by scoped name; widths come from the settings header.
 */
`include "beamformer_settings.svh"

package beamformer_pkg;

    // a single signed input or output sample
    typedef logic signed [`BF_SAMPLE_WIDTH-1:0] sample_t;

    // one part of a complex weight, signed Q1.6
    typedef logic signed [`BF_WEIGHT_WIDTH-1:0] weight_t;

    // full precision of a sample times a weight part
    // the wider sums in the weighter wrap here, which is harmless since only
    // bits above the fraction and below 16 more are kept
    typedef logic signed [`BF_SAMPLE_WIDTH+`BF_WEIGHT_WIDTH-1:0] product_t;

    // a stream beat, sample 0 in the low bits
    typedef logic [`BF_BEAT_WIDTH-1:0] beat_t;

    // packet tracking for the weight capture
    // wait_first means the next accepted beat opens a packet
    typedef enum logic {
        wait_first,
        in_packet
    } packet_state_t;

endpackage

//--- hw/beamformer_settings.svh
/*
 * Fixed widths and counts for the four-channel complex beamformer.
 * Included by the package and by every RTL module that slices beats or
 * sizes weight buses. The include guard keeps repeated includes harmless.
 */
`ifndef BEAMFORMER_SETTINGS_SVH
`define BEAMFORMER_SETTINGS_SVH

// one signed sample inside a stream beat
`define BF_SAMPLE_WIDTH 16

// one signed weight part, either real or imaginary
`define BF_WEIGHT_WIDTH 8

// weights are Q1.6, so 64 stands for 1.0
`define BF_WEIGHT_FRAC 6

// samples carried side by side in one beat
`define BF_SAMPLES 8

// antenna channels that are weighted and summed
`define BF_CHANNELS 4

// a whole beat, eight samples of 16 bits
`define BF_BEAT_WIDTH 128

`endif

//--- hw/beamformer_top.sv
/*
 * Four-channel complex beamformer on ready/valid streams.
 * Each channel brings a real and an imaginary stream of eight samples per beat;
 * the weighted channels are summed into one beam. Only ch00 real carries tlast.
 * Latency is three register stages, all held together under back-pressure.
 */
`timescale 1ns/1ps

module beamformer_top (
    input  logic                    clock,
    input  logic                    resetn,
    // channel streams, all ready outputs move together
    input  logic                    ch00_real_valid,
    output logic                    ch00_real_ready,
    input  beamformer_pkg::beat_t   ch00_real_data,
    input  logic                    ch00_real_last,
    input  logic                    ch00_imag_valid,
    output logic                    ch00_imag_ready,
    input  beamformer_pkg::beat_t   ch00_imag_data,
    input  logic                    ch01_real_valid,
    output logic                    ch01_real_ready,
    input  beamformer_pkg::beat_t   ch01_real_data,
    input  logic                    ch01_imag_valid,
    output logic                    ch01_imag_ready,
    input  beamformer_pkg::beat_t   ch01_imag_data,
    input  logic                    ch20_real_valid,
    output logic                    ch20_real_ready,
    input  beamformer_pkg::beat_t   ch20_real_data,
    input  logic                    ch20_imag_valid,
    output logic                    ch20_imag_ready,
    input  beamformer_pkg::beat_t   ch20_imag_data,
    input  logic                    ch21_real_valid,
    output logic                    ch21_real_ready,
    input  beamformer_pkg::beat_t   ch21_real_data,
    input  logic                    ch21_imag_valid,
    output logic                    ch21_imag_ready,
    input  beamformer_pkg::beat_t   ch21_imag_data,
    // complex weights, Q1.6
    input  beamformer_pkg::weight_t weight_00_real,
    input  beamformer_pkg::weight_t weight_00_imag,
    input  beamformer_pkg::weight_t weight_01_real,
    input  beamformer_pkg::weight_t weight_01_imag,
    input  beamformer_pkg::weight_t weight_20_real,
    input  beamformer_pkg::weight_t weight_20_imag,
    input  beamformer_pkg::weight_t weight_21_real,
    input  beamformer_pkg::weight_t weight_21_imag,
    // combined beam
    output beamformer_pkg::beat_t   beam_real_data,
    output beamformer_pkg::beat_t   beam_imag_data,
    output logic                    beam_valid,
    output logic                    beam_last,
    input  logic                    beam_ready
);

    logic                    in_ready;
    logic                    accept;
    logic                    advance;
    beamformer_pkg::weight_t active_00_real;
    beamformer_pkg::weight_t active_00_imag;
    beamformer_pkg::weight_t active_01_real;
    beamformer_pkg::weight_t active_01_imag;
    beamformer_pkg::weight_t active_20_real;
    beamformer_pkg::weight_t active_20_imag;
    beamformer_pkg::weight_t active_21_real;
    beamformer_pkg::weight_t active_21_imag;
    beamformer_pkg::beat_t   weighted_00_real;
    beamformer_pkg::beat_t   weighted_00_imag;
    beamformer_pkg::beat_t   weighted_01_real;
    beamformer_pkg::beat_t   weighted_01_imag;
    beamformer_pkg::beat_t   weighted_20_real;
    beamformer_pkg::beat_t   weighted_20_imag;
    beamformer_pkg::beat_t   weighted_21_real;
    beamformer_pkg::beat_t   weighted_21_imag;

    // the eight streams are joined, so they share one ready
    assign ch00_real_ready = in_ready;
    assign ch00_imag_ready = in_ready;
    assign ch01_real_ready = in_ready;
    assign ch01_imag_ready = in_ready;
    assign ch20_real_ready = in_ready;
    assign ch20_imag_ready = in_ready;
    assign ch21_real_ready = in_ready;
    assign ch21_imag_ready = in_ready;

    pipeline_control control (
        .clock(clock), .resetn(resetn),
        .valid_00_real(ch00_real_valid), .valid_00_imag(ch00_imag_valid),
        .valid_01_real(ch01_real_valid), .valid_01_imag(ch01_imag_valid),
        .valid_20_real(ch20_real_valid), .valid_20_imag(ch20_imag_valid),
        .valid_21_real(ch21_real_valid), .valid_21_imag(ch21_imag_valid),
        .head_last(ch00_real_last), .beam_ready(beam_ready),
        .in_ready(in_ready), .accept(accept), .advance(advance),
        .beam_valid(beam_valid), .beam_last(beam_last)
    );

    weight_bank weights (
        .clock(clock), .resetn(resetn), .accept(accept), .head_last(ch00_real_last),
        .weight_00_real(weight_00_real), .weight_00_imag(weight_00_imag),
        .weight_01_real(weight_01_real), .weight_01_imag(weight_01_imag),
        .weight_20_real(weight_20_real), .weight_20_imag(weight_20_imag),
        .weight_21_real(weight_21_real), .weight_21_imag(weight_21_imag),
        .active_00_real(active_00_real), .active_00_imag(active_00_imag),
        .active_01_real(active_01_real), .active_01_imag(active_01_imag),
        .active_20_real(active_20_real), .active_20_imag(active_20_imag),
        .active_21_real(active_21_real), .active_21_imag(active_21_imag)
    );

    channel_weighter ch00_weighter (
        .clock(clock), .advance(advance),
        .data_real(ch00_real_data), .data_imag(ch00_imag_data),
        .weight_real(active_00_real), .weight_imag(active_00_imag),
        .weighted_real(weighted_00_real), .weighted_imag(weighted_00_imag)
    );

    channel_weighter ch01_weighter (
        .clock(clock), .advance(advance),
        .data_real(ch01_real_data), .data_imag(ch01_imag_data),
        .weight_real(active_01_real), .weight_imag(active_01_imag),
        .weighted_real(weighted_01_real), .weighted_imag(weighted_01_imag)
    );

    channel_weighter ch20_weighter (
        .clock(clock), .advance(advance),
        .data_real(ch20_real_data), .data_imag(ch20_imag_data),
        .weight_real(active_20_real), .weight_imag(active_20_imag),
        .weighted_real(weighted_20_real), .weighted_imag(weighted_20_imag)
    );

    channel_weighter ch21_weighter (
        .clock(clock), .advance(advance),
        .data_real(ch21_real_data), .data_imag(ch21_imag_data),
        .weight_real(active_21_real), .weight_imag(active_21_imag),
        .weighted_real(weighted_21_real), .weighted_imag(weighted_21_imag)
    );

    beam_summer summer (
        .clock(clock), .advance(advance),
        .real_00(weighted_00_real), .real_01(weighted_01_real),
        .real_20(weighted_20_real), .real_21(weighted_21_real),
        .imag_00(weighted_00_imag), .imag_01(weighted_01_imag),
        .imag_20(weighted_20_imag), .imag_21(weighted_21_imag),
        .beam_real_data(beam_real_data), .beam_imag_data(beam_imag_data)
    );

endmodule

//--- hw/channel_weighter.sv
/*
 * Complex weighting of one channel, eight samples per beat.
 * Stage one registers the four partial products of every sample, stage two
 * combines them into real and imaginary parts and drops the fraction bits.
 * Both stages load only when the pipeline advances.
 */
`timescale 1ns/1ps
`include "beamformer_settings.svh"

module channel_weighter (
    input  logic                    clock,
    input  logic                    advance,
    input  beamformer_pkg::beat_t   data_real,
    input  beamformer_pkg::beat_t   data_imag,
    input  beamformer_pkg::weight_t weight_real,
    input  beamformer_pkg::weight_t weight_imag,
    output beamformer_pkg::beat_t   weighted_real,
    output beamformer_pkg::beat_t   weighted_imag
);

    // partial products, named by sample part then weight part
    beamformer_pkg::product_t prod_rr [`BF_SAMPLES];
    beamformer_pkg::product_t prod_ii [`BF_SAMPLES];
    beamformer_pkg::product_t prod_ri [`BF_SAMPLES];
    beamformer_pkg::product_t prod_ir [`BF_SAMPLES];
    beamformer_pkg::beat_t    next_real;
    beamformer_pkg::beat_t    next_imag;

    // picks one signed sample out of a beat
    function automatic beamformer_pkg::sample_t sample_of(input beamformer_pkg::beat_t beat,
                                                          input int index);
        return beat[index*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH];
    endfunction

    // both operands are signed, so they sign extend to the product width
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int s = 0; s < `BF_SAMPLES; s++) begin
                prod_rr[s] <= sample_of(data_real, s) * weight_real;
                prod_ii[s] <= sample_of(data_imag, s) * weight_imag;
                prod_ri[s] <= sample_of(data_real, s) * weight_imag;
                prod_ir[s] <= sample_of(data_imag, s) * weight_real;
            end
        end
    end

    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    always_comb begin
        beamformer_pkg::product_t re_sum;
        beamformer_pkg::product_t im_sum;
        next_real = '0;
        next_imag = '0;
        for (int s = 0; s < `BF_SAMPLES; s++) begin
            re_sum = prod_rr[s] - prod_ii[s];
            im_sum = prod_ri[s] + prod_ir[s];
            // scale back from Q1.6, the cast keeps the low 16 bits and wraps
            next_real[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH] =
                beamformer_pkg::sample_t'(re_sum >>> `BF_WEIGHT_FRAC);
            next_imag[s*`BF_SAMPLE_WIDTH +: `BF_SAMPLE_WIDTH] =
                beamformer_pkg::sample_t'(im_sum >>> `BF_WEIGHT_FRAC);
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            weighted_real <= next_real;
            weighted_imag <= next_imag;
        end
    end

endmodule

//--- hw/pipeline_control.sv
/*
 * Flow control for the beamformer pipeline.
 * Joins the eight input valids, decides when a beat is accepted and when the
 * three register stages advance, and carries valid and last alongside the data.
 * The last stage of the valid and last shift drives the output handshake.
 */
`timescale 1ns/1ps

module pipeline_control (
    input  logic clock,
    input  logic resetn,
    input  logic valid_00_real,
    input  logic valid_00_imag,
    input  logic valid_01_real,
    input  logic valid_01_imag,
    input  logic valid_20_real,
    input  logic valid_20_imag,
    input  logic valid_21_real,
    input  logic valid_21_imag,
    input  logic head_last,
    input  logic beam_ready,
    output logic in_ready,
    output logic accept,
    output logic advance,
    output logic beam_valid,
    output logic beam_last
);

    logic       all_valid;
    logic       started;
    logic [2:0] valid_pipe;
    logic [2:0] last_pipe;

    // a beat only enters when every one of the eight streams offers data
    assign all_valid = &{valid_00_real, valid_00_imag, valid_01_real, valid_01_imag,
                         valid_20_real, valid_20_imag, valid_21_real, valid_21_imag};

    // the pipeline moves when the output slot is empty or being drained
    assign advance = !valid_pipe[2] || beam_ready;

    // started holds ready low through reset and the first cycle after it
    assign in_ready = started && advance && all_valid;

    // every ready cycle is a transfer since ready already includes the valids
    assign accept = in_ready;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            started    <= 1'b0;
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            started <= 1'b1;
            // bit 0 pairs with the products, bit 1 with the weighted beats
            // and bit 2 with the summed beam registers
            if (advance) begin
                valid_pipe <= {valid_pipe[1:0], accept};
                last_pipe  <= {last_pipe[1:0], accept && head_last};
            end
        end
    end

    // when stalled the top bits simply hold, so the output stays stable
    assign beam_valid = valid_pipe[2];
    assign beam_last  = last_pipe[2];

endmodule

//--- hw/weight_bank.sv
/*
 * Holds the eight complex weight parts for the duration of a packet.
 * The first accepted beat of a packet uses the live weight inputs and
 * captures them; later beats of that packet see the captured copy.
 */
`timescale 1ns/1ps
`include "beamformer_settings.svh"

module weight_bank (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    accept,
    input  logic                    head_last,
    input  beamformer_pkg::weight_t weight_00_real,
    input  beamformer_pkg::weight_t weight_00_imag,
    input  beamformer_pkg::weight_t weight_01_real,
    input  beamformer_pkg::weight_t weight_01_imag,
    input  beamformer_pkg::weight_t weight_20_real,
    input  beamformer_pkg::weight_t weight_20_imag,
    input  beamformer_pkg::weight_t weight_21_real,
    input  beamformer_pkg::weight_t weight_21_imag,
    output beamformer_pkg::weight_t active_00_real,
    output beamformer_pkg::weight_t active_00_imag,
    output beamformer_pkg::weight_t active_01_real,
    output beamformer_pkg::weight_t active_01_imag,
    output beamformer_pkg::weight_t active_20_real,
    output beamformer_pkg::weight_t active_20_imag,
    output beamformer_pkg::weight_t active_21_real,
    output beamformer_pkg::weight_t active_21_imag
);

    beamformer_pkg::packet_state_t                      state;
    logic [2*`BF_CHANNELS*`BF_WEIGHT_WIDTH-1:0]         live;
    logic [2*`BF_CHANNELS*`BF_WEIGHT_WIDTH-1:0]         held;
    logic [2*`BF_CHANNELS*`BF_WEIGHT_WIDTH-1:0]         shown;

    // all eight parts travel as one word, real before imag per channel
    assign live = {weight_00_real, weight_00_imag, weight_01_real, weight_01_imag,
                   weight_20_real, weight_20_imag, weight_21_real, weight_21_imag};

    // between packets the live weights go straight to the multipliers
    assign shown = (state == beamformer_pkg::wait_first) ? live : held;

    assign {active_00_real, active_00_imag, active_01_real, active_01_imag,
            active_20_real, active_20_imag, active_21_real, active_21_imag} = shown;

    // a packet opens on any accepted beat and closes on the beat with tlast
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= beamformer_pkg::wait_first;
        end else if (accept) begin
            state <= head_last ? beamformer_pkg::wait_first : beamformer_pkg::in_packet;
        end
    end

    // capture happens only on the opening beat
    always_ff @(posedge clock) begin
        if (accept && state == beamformer_pkg::wait_first) begin
            held <= live;
        end
    end

endmodule

//--- src.f
+incdir+hw
hw/beamformer_pkg.sv
hw/pipeline_control.sv
hw/weight_bank.sv
hw/channel_weighter.sv
hw/beam_summer.sv
hw/beamformer_top.sv
tb/beamformer_assertions.sv
tb/beamformer_tb.sv

//--- tb/beamformer_assertions.sv
/*
 * Concurrent protocol checks on the beamformer top level.
 * Bound into every beamformer_top instance; the testbench reads the failure count.
 */
`timescale 1ns/1ps

module beamformer_assertions (
    input logic                  clock,
    input logic                  resetn,
    input logic                  in_ready,
    input logic                  beam_valid,
    input logic                  beam_ready,
    input logic                  beam_last,
    input beamformer_pkg::beat_t beam_real_data,
    input beamformer_pkg::beat_t beam_imag_data
);

    int failures = 0;

    // a stalled output beat must not change or vanish
    assert property (@(posedge clock) disable iff (!resetn)
        beam_valid && !beam_ready |=> beam_valid && $stable(beam_last) &&
        $stable(beam_real_data) && $stable(beam_imag_data))
        else begin
            failures++;
            $error("output beat changed while stalled");
        end

    // no input is taken while the design is held in reset
    assert property (@(posedge clock) !resetn |-> !in_ready)
        else begin
            failures++;
            $error("input ready high during reset");
        end

    assert property (@(posedge clock) disable iff (!resetn) !$isunknown(beam_valid))
        else begin
            failures++;
            $error("beam_valid unknown");
        end

endmodule

bind beamformer_top beamformer_assertions assertions (
    .clock(clock), .resetn(resetn), .in_ready(in_ready),
    .beam_valid(beam_valid), .beam_ready(beam_ready), .beam_last(beam_last),
    .beam_real_data(beam_real_data), .beam_imag_data(beam_imag_data)
);

//--- tb/beamformer_input.txt
# W: weights 00r 00i 01r 01i 20r 20i 21r 21i; F: tlast ch00 real imag; C: ch01/ch20/ch21 real imag
# E: expected last, beam real, beam imag; sample 7 leftmost in every beat
W 40 00 40 00 40 00 40 00
F 0 00010002000300040005000600077000 FFFFFFFF000000000000000000008000
C 00100020003000400050006000707000 FFFF0001000000000000000000008000
C 01000200030004000500060007007000 FFFF0000000000000000000000000001
C 10002000300040005000600070007000 FFFF0000000000000000000012340002
E 0 1111222233334444555566667777C000 FFFC0000000000000000000012340003
F 1 00010001000100010001000100010001 00000000000000000000000000000000
C 00020002000200020002000200020002 00000000000000000000000000000000
C 00030003000300030003000300030003 00000000000000000000000000000000
C 00040004000400040004000400040004 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
E 1 000A000A000A000A000A000A000A000A FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
W 40 C0 20 20 80 00 00 40
F 0 00640064006400640064006400640064 FFFDFFFDFFFDFFFDFFFDFFFDFFFDFFFD
C 00400040004000400040004000400040 00410041004100410041004100410041
C 70007000700070007000700070007000 00050005000500050005000500050005
C 00100010001000100010001000100010 00200020002000200020002000200020
E 0 20402040204020402040204020402040 FFDFFFDFFFDFFFDFFFDFFFDFFFDFFFDF
W 00 40 00 40 00 40 00 40
F 1 FFC0FFC0FFC0FFC0FFC0FFC0FFC0FFC0 00000000000000000000000000000000
C 00000000000000000000000000000000 00000000000000000000000000000000
C 00010001000100010001000100010001 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
C 00000000000000000000000000000000 01000100010001000100010001000100
E 1 FEBEFEBEFEBEFEBEFEBEFEBEFEBEFEBE 00420042004200420042004200420042
F 1 00080007000600050004000300020001 00010001000100010001000100010001
C 00000000000000000000000000000000 00020002000200020002000200020002
C 00100010001000100010001000100010 80008000800080008000800080008000
C 00000000000000000000000000000000 80008000800080008000800080008000
E 1 FFFDFFFDFFFDFFFDFFFDFFFDFFFDFFFD 00180017001600150014001300120011

//--- tb/beamformer_tb.sv
/*
 * Testbench for the four-channel complex beamformer.
 * Reads weight, beat and expected records from the input data file, plays the
 * beat list twice (first at full rate, then with random gaps and back-pressure)
 * and compares every output beat in order against the expected records.
 */
`timescale 1ns/1ps

module beamformer_tb;

    localparam string       input_file     = "tb/beamformer_input.txt";
    localparam logic [15:0] lfsr_seed      = 16'd24119;
    localparam int          reset_cycles   = 8;
    localparam int          timeout_margin = 100;
    localparam int          max_beats      = 32;

    logic clock = 1'b0;
    logic resetn;
    logic ch00_real_valid, ch00_imag_valid, ch01_real_valid, ch01_imag_valid;
    logic ch20_real_valid, ch20_imag_valid, ch21_real_valid, ch21_imag_valid;
    logic ch00_real_ready, ch00_imag_ready, ch01_real_ready, ch01_imag_ready;
    logic ch20_real_ready, ch20_imag_ready, ch21_real_ready, ch21_imag_ready;
    logic [127:0] ch00_real_data, ch00_imag_data, ch01_real_data, ch01_imag_data;
    logic [127:0] ch20_real_data, ch20_imag_data, ch21_real_data, ch21_imag_data;
    logic ch00_real_last;
    logic [7:0] weight_00_real, weight_00_imag, weight_01_real, weight_01_imag;
    logic [7:0] weight_20_real, weight_20_imag, weight_21_real, weight_21_imag;
    logic [127:0] beam_real_data, beam_imag_data;
    logic beam_valid, beam_last, beam_ready;

    // stimulus and expected records as loaded from the data file
    logic [127:0] beat_data [max_beats][8];
    logic         beat_last [max_beats];
    logic [63:0]  beat_weights [max_beats];
    logic [127:0] exp_real [max_beats];
    logic [127:0] exp_imag [max_beats];
    logic         exp_last [max_beats];
    int           nbeats = 0;
    int           nexp = 0;
    int           exp_queue [$];

    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    int          current_pass = 0;
    logic [15:0] lfsr;
    bit          load_ok;

    beamformer_top uut (.*);

    // 40 ns clock period
    always #20 clock = ~clock;

    // the run is bounded by the cycle limit set once the beat count is known
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: outputs still missing after %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // F opens a beat with ch00 and tlast, three C lines follow for ch01, ch20, ch21
    task automatic load_stimulus(output bit ok);
        int           fd;
        int           code;
        int           ch;
        string        line;
        logic         flag;
        logic [127:0] re;
        logic [127:0] im;
        logic [7:0]   w0, w1, w2, w3, w4, w5, w6, w7;
        logic [63:0]  weights;
        ch = 0;
        weights = '0;
        fd = $fopen(input_file, "r");
        if (fd == 0) begin
            $display("the stimulus file %s could not be opened", input_file);
            ok = 0;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2) continue;
            if (line[0] == "W") begin
                code = $sscanf(line, "W %h %h %h %h %h %h %h %h",
                               w0, w1, w2, w3, w4, w5, w6, w7);
                weights = {w0, w1, w2, w3, w4, w5, w6, w7};
            end else if (line[0] == "F") begin
                code = $sscanf(line, "F %h %h %h", flag, re, im);
                beat_last[nbeats] = flag;
                beat_data[nbeats][0] = re;
                beat_data[nbeats][1] = im;
                ch = 1;
            end else if (line[0] == "C") begin
                code = $sscanf(line, "C %h %h", re, im);
                beat_data[nbeats][2*ch] = re;
                beat_data[nbeats][2*ch+1] = im;
                ch++;
                if (ch == 4) begin
                    beat_weights[nbeats] = weights;
                    nbeats++;
                end
            end else if (line[0] == "E") begin
                code = $sscanf(line, "E %h %h %h", flag, re, im);
                exp_last[nexp] = flag;
                exp_real[nexp] = re;
                exp_imag[nexp] = im;
                nexp++;
            end
        end
        $fclose(fd);
        ok = (nbeats > 0 && nbeats == nexp);
        if (!ok) $display("the stimulus file has %0d beats but %0d expected beats", nbeats, nexp);
    endtask

    task automatic set_valids(input logic value);
        ch00_real_valid <= value;
        ch00_imag_valid <= value;
        ch01_real_valid <= value;
        ch01_imag_valid <= value;
        ch20_real_valid <= value;
        ch20_imag_valid <= value;
        ch21_real_valid <= value;
        ch21_imag_valid <= value;
    endtask

    // weights change together with the beat, so mid-packet changes are visible
    task automatic drive_beat(input int i);
        ch00_real_data <= beat_data[i][0];
        ch00_imag_data <= beat_data[i][1];
        ch01_real_data <= beat_data[i][2];
        ch01_imag_data <= beat_data[i][3];
        ch20_real_data <= beat_data[i][4];
        ch20_imag_data <= beat_data[i][5];
        ch21_real_data <= beat_data[i][6];
        ch21_imag_data <= beat_data[i][7];
        ch00_real_last <= beat_last[i];
        {weight_00_real, weight_00_imag, weight_01_real, weight_01_imag,
         weight_20_real, weight_20_imag, weight_21_real, weight_21_imag} <= beat_weights[i];
        set_valids(1'b1);
    endtask

    task automatic compare_output();
        int e;
        if (exp_queue.size() == 0) begin
            errors++;
            $display("an output beat arrived with no expected beat left to match it");
        end else begin
            e = exp_queue.pop_front();
            check_value($sformatf("pass %0d beat %0d real", current_pass, e),
                        exp_real[e], beam_real_data);
            check_value($sformatf("pass %0d beat %0d imag", current_pass, e),
                        exp_imag[e], beam_imag_data);
            check_value($sformatf("pass %0d beat %0d last", current_pass, e),
                        exp_last[e], beam_last);
        end
    endtask

    // one cycle per iteration, driven on the rising edge and sampled mid-cycle
    task automatic run_pass(input bit random_flow);
        int idx;
        bit pending;
        idx = 0;
        pending = 0;
        for (int e = 0; e < nexp; e++) exp_queue.push_back(e);
        while (idx < nbeats || exp_queue.size() != 0) begin
            @(posedge clock);
            if (!pending) begin
                if (idx < nbeats && !(random_flow && random_bit() && random_bit())) begin
                    drive_beat(idx);
                    pending = 1;
                end else begin
                    set_valids(1'b0);
                end
            end
            beam_ready <= random_flow ? !(random_bit() && random_bit()) : 1'b1;
            @(negedge clock);
            if (pending && ch00_real_ready) begin
                idx++;
                pending = 0;
            end
            if (beam_valid && beam_ready) compare_output();
        end
    endtask

    initial begin
        resetn = 1'b0;
        {ch00_real_valid, ch00_imag_valid, ch01_real_valid, ch01_imag_valid,
         ch20_real_valid, ch20_imag_valid, ch21_real_valid, ch21_imag_valid} = '0;
        {ch00_real_data, ch00_imag_data, ch01_real_data, ch01_imag_data,
         ch20_real_data, ch20_imag_data, ch21_real_data, ch21_imag_data} = '0;
        ch00_real_last = 1'b0;
        {weight_00_real, weight_00_imag, weight_01_real, weight_01_imag,
         weight_20_real, weight_20_imag, weight_21_real, weight_21_imag} = '0;
        beam_ready = 1'b0;
        lfsr = lfsr_seed;
        load_stimulus(load_ok);
        if (!load_ok) begin
            $display("Checks failed");
            $finish;
        end else begin
            limit = 4 * 2 * nbeats + reset_cycles + timeout_margin;
            // valids go high part way into reset so that ready is seen held low
            repeat (2) @(posedge clock);
            set_valids(1'b1);
            repeat (reset_cycles - 2) begin
                @(negedge clock);
                check_value("reset beam_valid", 0, beam_valid);
                check_value("reset ready", 0, {ch00_real_ready, ch00_imag_ready,
                            ch01_real_ready, ch01_imag_ready, ch20_real_ready,
                            ch20_imag_ready, ch21_real_ready, ch21_imag_ready});
                @(posedge clock);
            end
            resetn <= 1'b1;
            @(negedge clock);
            check_value("after reset beam_valid", 0, beam_valid);
            check_value("after reset ready", 0, {ch00_real_ready, ch00_imag_ready,
                        ch01_real_ready, ch01_imag_ready, ch20_real_ready,
                        ch20_imag_ready, ch21_real_ready, ch21_imag_ready});
            current_pass = 0;
            run_pass(0);
            current_pass = 1;
            run_pass(1);
            $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                     uut.assertions.failures);
            if (errors == 0 && uut.assertions.failures == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule
